// File: src/cache_pkg.sv
package cache_pkg;

	// Address field widths
	localparam int tag_bits = 6;
	localparam int index_bits = 6;
	localparam int word_bits = 3;

	// Cache geometry, two ways of this shape per cache
	localparam int sets = 64;
	localparam int words_per_block = 8;

	// Byte address as seen by both ports
	// Bit 0 selects a byte and is ignored, all accesses are whole words
	typedef struct packed {
		logic [tag_bits-1:0]   tag;
		logic [index_bits-1:0] index;
		logic [word_bits-1:0]  word;
		logic                  byte_sel;
	} cache_addr_t;

	// Stored metadata of one way in one set
	typedef struct packed {
		logic [tag_bits-1:0] tag;
		logic                valid;
	} meta_t;

	// One request from the memory stage
	// Core holds it steady while m_stall is high
	typedef struct packed {
		logic        read;
		logic        write;
		cache_addr_t addr;
		logic [15:0] wdata;
	} data_req_t;

	// One returning block word steered to the array being filled
	typedef struct packed {
		logic                 we;
		logic [word_bits-1:0] word;
		logic [15:0]          data;
	} fill_t;

endpackage

// File: src/memory4c.sv
module memory4c #(
	parameter int mem_latency = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic                   wr,
	input  cache_pkg::cache_addr_t addr,
	input  logic [15:0]            wdata,
	output logic [15:0]            rdata,
	output logic                   data_valid
);

	// Word count covered by tag, index and word fields
	localparam int addr_words = 1 << (cache_pkg::tag_bits + cache_pkg::index_bits
		+ cache_pkg::word_bits);

	logic [15:0] mem [addr_words];

	// Word address with the byte select dropped
	logic [14:0] word_addr;
	logic        rd_en;

	// Read pipeline with stage 0 loaded at the edge of the request
	logic [15:0]            rd_pipe [mem_latency];
	logic [mem_latency-1:0] vld_pipe;

	assign word_addr = {addr.tag, addr.index, addr.word};
	assign rd_en = enable && !wr;

	// Main memory powers up cleared
	initial begin
		for (int i = 0; i < addr_words; i++) begin
			mem[i] = '0;
		end
	end

	// Writes land at the edge and return nothing
	always_ff @(posedge clk) begin
		if (enable && wr)
			mem[word_addr] <= wdata;
	end

	// Read data moves one stage per cycle
	always_ff @(posedge clk) begin
		rd_pipe[0] <= mem[word_addr];
		for (int i = 1; i < mem_latency; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= rd_en;
			for (int i = 1; i < mem_latency; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
			end
		end
	end

	// Visible mem_latency cycles after the request cycle
	assign rdata = rd_pipe[mem_latency-1];
	assign data_valid = vld_pipe[mem_latency-1];

endmodule

// File: src/two_way_cache_array.sv
module two_way_cache_array (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cache_pkg::cache_addr_t addr,
	input  logic                   access,
	input  logic                   we,
	input  logic [15:0]            wdata,
	input  logic                   fill_start,
	input  cache_pkg::fill_t       fill,
	input  logic                   write_tag,
	output logic                   hit,
	output logic [15:0]            rdata
);

	// Metadata and block words, indexed by way then set
	cache_pkg::meta_t meta [2][cache_pkg::sets];
	logic [15:0]      data_words [2][cache_pkg::sets][cache_pkg::words_per_block];

	// Per set, the way to evict next
	logic [cache_pkg::sets-1:0] lru;

	// Fill target, latched at fill_start
	logic                             fill_way;
	logic [cache_pkg::index_bits-1:0] fill_set;
	logic [cache_pkg::tag_bits-1:0]   fill_tag;
	// High from fill_start until the tag is written
	logic                             filling;

	cache_pkg::meta_t meta0;
	cache_pkg::meta_t meta1;
	logic             hit0;
	logic             hit1;
	logic             victim;

	// Both ways of the addressed set
	assign meta0 = meta[0][addr.index];
	assign meta1 = meta[1][addr.index];

	// Tag compare against valid ways only
	assign hit0 = meta0.valid && (meta0.tag == addr.tag);
	assign hit1 = meta1.valid && (meta1.tag == addr.tag);
	assign hit = hit0 || hit1;

	// Way 0 unless way 1 matched
	assign rdata = hit1 ? data_words[1][addr.index][addr.word]
		: data_words[0][addr.index][addr.word];

	// Empty ways are taken before evicting anything
	always_comb begin
		if (!meta0.valid)
			victim = 1'b0;
		else if (!meta1.valid)
			victim = 1'b1;
		else
			victim = lru[addr.index];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < cache_pkg::sets; s++) begin
				meta[0][s] <= '0;
				meta[1][s] <= '0;
			end
			lru <= '0;
			filling <= 1'b0;
		end else begin
			// Hit in way 0 leaves way 1 as LRU and vice versa
			if (access && hit)
				lru[addr.index] <= hit0;
			// Victim drops out so nothing half-filled can hit
			if (fill_start) begin
				meta[victim][addr.index].valid <= 1'b0;
				filling <= 1'b1;
			end
			if (write_tag) begin
				meta[fill_way][fill_set] <= '{tag: fill_tag, valid: 1'b1};
				lru[fill_set] <= !fill_way;
				filling <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start) begin
			fill_way <= victim;
			fill_set <= addr.index;
			fill_tag <= addr.tag;
		end
	end

	// Fill beats and hit writes never coincide, the top gates writes while busy
	always_ff @(posedge clk) begin
		if (fill.we)
			data_words[fill_way][fill_set][fill.word] <= fill.data;
		else if (we && hit)
			data_words[hit1][addr.index][addr.word] <= wdata;
	end

	// Beats and the tag write only follow a started fill
	a_fill_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		(fill.we || write_tag) |-> filling)
		else $error("fill beat or tag write without fill_start");

endmodule

// File: src/cache_fill_fsm.sv
module cache_fill_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_miss,
	input  logic                   data_miss,
	input  cache_pkg::cache_addr_t instr_base,
	input  cache_pkg::cache_addr_t data_base,
	input  logic                   mem_valid,
	input  logic [15:0]            mem_rdata,
	output logic                   busy,
	output logic                   mem_read,
	output cache_pkg::cache_addr_t mem_addr,
	output logic                   instr_fill_start,
	output logic                   data_fill_start,
	output cache_pkg::fill_t       instr_fill,
	output cache_pkg::fill_t       data_fill,
	output logic                   instr_write_tag,
	output logic                   data_write_tag
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_request = 2'd1;
	localparam logic [1:0] st_drain = 2'd2;
	localparam logic [1:0] st_tag = 2'd3;

	// Block size is a power of two, so the last word is all ones
	localparam logic [cache_pkg::word_bits-1:0] last_word = '1;

	logic [1:0]                      state;
	// 0 fills the instruction cache, 1 the data cache
	logic                            fill_side;
	cache_pkg::cache_addr_t          base;
	// Reads issued and words returned
	logic [cache_pkg::word_bits-1:0] req_cnt;
	logic [cache_pkg::word_bits-1:0] beat_cnt;
	logic                            start;
	logic                            beat;

	assign busy = (state != st_idle);

	// Instruction miss wins when both are present
	assign start = (state == st_idle) && (instr_miss || data_miss);
	assign instr_fill_start = (state == st_idle) && instr_miss;
	assign data_fill_start = (state == st_idle) && !instr_miss && data_miss;

	// One read per cycle, word 0 first
	assign mem_read = (state == st_request);
	assign mem_addr = '{tag: base.tag, index: base.index, word: req_cnt, byte_sel: 1'b0};

	// Returning words arrive in request order
	assign beat = mem_valid && busy;
	assign instr_fill = '{we: beat && !fill_side, word: beat_cnt, data: mem_rdata};
	assign data_fill = '{we: beat && fill_side, word: beat_cnt, data: mem_rdata};

	assign instr_write_tag = (state == st_tag) && !fill_side;
	assign data_write_tag = (state == st_tag) && fill_side;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			fill_side <= 1'b0;
			req_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			if (beat)
				beat_cnt <= beat_cnt + 1'b1;
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_request;
						fill_side <= !instr_miss;
						req_cnt <= '0;
						beat_cnt <= '0;
					end
				end
				st_request: begin
					req_cnt <= req_cnt + 1'b1;
					if (req_cnt == last_word)
						state <= st_drain;
				end
				// Wait out the memory latency for the last words
				st_drain: begin
					if (mem_valid && beat_cnt == last_word)
						state <= st_tag;
				end
				st_tag: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Block base of the side being filled
	always_ff @(posedge clk) begin
		if (start)
			base <= instr_miss ? instr_base : data_base;
	end

	// Memory only answers reads this FSM issued
	a_valid_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid |-> busy)
		else $error("memory data_valid while fill FSM idle");

endmodule

// File: src/cache_subsystem.sv
module cache_subsystem #(
	parameter int mem_latency = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_read,
	input  cache_pkg::cache_addr_t instr_addr,
	input  cache_pkg::data_req_t   data_req,
	output logic [15:0]            instr_data,
	output logic [15:0]            data_rdata,
	output logic                   f_stall,
	output logic                   m_stall
);

	// Hit and miss per side
	logic instr_hit;
	logic data_hit;
	logic instr_miss;
	logic data_miss;
	logic data_access;
	logic data_wr_hit;

	// Fill FSM side
	logic                   fsm_busy;
	logic                   fsm_read;
	cache_pkg::cache_addr_t fsm_addr;
	logic                   instr_fill_start;
	logic                   data_fill_start;
	cache_pkg::fill_t       instr_fill;
	cache_pkg::fill_t       data_fill;
	logic                   instr_write_tag;
	logic                   data_write_tag;

	// High when the latest fill start went to the data array
	logic                   data_side;

	// Shared memory port
	logic                   mem_enable;
	logic                   mem_wr;
	cache_pkg::cache_addr_t mem_addr;
	logic [15:0]            mem_rdata;
	logic                   mem_valid;

	assign data_access = data_req.read || data_req.write;
	assign instr_miss = instr_read && !instr_hit;
	assign data_miss = data_access && !data_hit;

	// Write-through hit only when the memory port is free
	assign data_wr_hit = data_req.write && data_hit && !fsm_busy;

	// Instruction side never writes
	two_way_cache_array i_instr_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (instr_addr),
		.access     (instr_read),
		.we         (1'b0),
		.wdata      (16'h0000),
		.fill_start (instr_fill_start),
		.fill       (instr_fill),
		.write_tag  (instr_write_tag),
		.hit        (instr_hit),
		.rdata      (instr_data)
	);

	two_way_cache_array i_data_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (data_req.addr),
		.access     (data_access),
		.we         (data_wr_hit),
		.wdata      (data_req.wdata),
		.fill_start (data_fill_start),
		.fill       (data_fill),
		.write_tag  (data_write_tag),
		.hit        (data_hit),
		.rdata      (data_rdata)
	);

	cache_fill_fsm i_fill_fsm (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr_miss       (instr_miss),
		.data_miss        (data_miss),
		.instr_base       (instr_addr),
		.data_base        (data_req.addr),
		.mem_valid        (mem_valid),
		.mem_rdata        (mem_rdata),
		.busy             (fsm_busy),
		.mem_read         (fsm_read),
		.mem_addr         (fsm_addr),
		.instr_fill_start (instr_fill_start),
		.data_fill_start  (data_fill_start),
		.instr_fill       (instr_fill),
		.data_fill        (data_fill),
		.instr_write_tag  (instr_write_tag),
		.data_write_tag   (data_write_tag)
	);

	// FSM owns memory during a fill and a hitting data write otherwise
	assign mem_enable = fsm_busy ? fsm_read : data_wr_hit;
	assign mem_wr = !fsm_busy && data_wr_hit;
	assign mem_addr = fsm_busy ? fsm_addr : data_req.addr;

	memory4c #(
		.mem_latency (mem_latency)
	) i_memory (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (mem_enable),
		.wr         (mem_wr),
		.addr       (mem_addr),
		.wdata      (data_req.wdata),
		.rdata      (mem_rdata),
		.data_valid (mem_valid)
	);

	// Stall while missing; writes also wait for the memory port
	assign f_stall = instr_read && instr_miss;
	assign m_stall = data_access && (data_miss || (data_req.write && fsm_busy));

	// Side of the fill in progress
	always_ff @(posedge clk) begin
		if (!rst_n)
			data_side <= 1'b0;
		else if (instr_fill_start)
			data_side <= 1'b0;
		else if (data_fill_start)
			data_side <= 1'b1;
	end

	// Beats reach only the array whose fill started last, never both at once
	a_one_fill: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_fill.we || data_fill.we) |->
			((data_fill.we == data_side) && (instr_fill.we != data_side)))
		else $error("fill beat sent to an array that is not being filled");

	// Held request hits once its block is tagged
	a_instr_hit_after_fill: assert property (@(posedge clk) disable iff (!rst_n)
		instr_write_tag |=> !instr_miss)
		else $error("instruction miss after its fill completed");

	a_data_hit_after_fill: assert property (@(posedge clk) disable iff (!rst_n)
		data_write_tag |=> !data_miss)
		else $error("data miss after its fill completed");

endmodule

// File: test/cache_tb.sv
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Two fills at the default latency take under 30 cycles
	localparam int wait_limit = 200;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_read;
	cache_pkg::cache_addr_t instr_addr;
	cache_pkg::data_req_t   data_req;
	logic [15:0]            instr_data;
	logic [15:0]            data_rdata;
	logic                   f_stall;
	logic                   m_stall;

	// Expected responses, updated on the falling edge with each request
	logic        chk_f_stall;
	logic        exp_f_stall;
	logic        chk_m_stall;
	logic        exp_m_stall;
	logic        chk_instr;
	logic        chk_data;
	logic        chk_order;
	logic [15:0] exp_instr;
	logic [15:0] exp_data;

	int          error_count;
	int          test_count;
	int          failed_tests;
	logic [31:0] lfsr_state;

	// Words written through the data port, keyed by word address
	logic [15:0] ref_mem [logic [14:0]];
	// Resident tags per cache and set, slot 0 most recently used
	logic [cache_pkg::tag_bits-1:0] res_tag [2][cache_pkg::sets][2];
	logic                           res_valid [2][cache_pkg::sets][2];

	cache_subsystem #(
		.mem_latency (4)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_read (instr_read),
		.instr_addr (instr_addr),
		.data_req   (data_req),
		.instr_data (instr_data),
		.data_rdata (data_rdata),
		.f_stall    (f_stall),
		.m_stall    (m_stall)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Stall level in the first cycle of a request, or during idle
	a_f_stall: assert property (@(posedge clk) disable iff (!rst_n)
		chk_f_stall |-> (f_stall == exp_f_stall))
		else begin
			error_count++;
			$display("CHECK FAILED time=%0t f_stall exp=%b got=%b", $time,
				$sampled(exp_f_stall), $sampled(f_stall));
		end

	a_m_stall: assert property (@(posedge clk) disable iff (!rst_n)
		chk_m_stall |-> (m_stall == exp_m_stall))
		else begin
			error_count++;
			$display("CHECK FAILED time=%0t m_stall exp=%b got=%b", $time,
				$sampled(exp_m_stall), $sampled(m_stall));
		end

	// Served words against the reference memory
	a_instr_data: assert property (@(posedge clk) disable iff (!rst_n)
		(chk_instr && instr_read && !f_stall) |-> (instr_data == exp_instr))
		else begin
			error_count++;
			$display("CHECK FAILED time=%0t instr_data exp=%h got=%h", $time,
				$sampled(exp_instr), $sampled(instr_data));
		end

	a_data_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		(chk_data && data_req.read && !m_stall) |-> (data_rdata == exp_data))
		else begin
			error_count++;
			$display("CHECK FAILED time=%0t data_rdata exp=%h got=%h", $time,
				$sampled(exp_data), $sampled(data_rdata));
		end

	// Instruction fill goes first, so fetch must be released no later than data
	a_fetch_first: assert property (@(posedge clk) disable iff (!rst_n)
		chk_order |-> !(f_stall && !m_stall))
		else begin
			error_count++;
			$display("data request released while fetch still stalled at time %0t", $time);
		end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic random_addr(output logic [15:0] a);
		logic [31:0] r;
		draw_bits(15, r);
		a = {r[14:0], 1'b0};
	endtask

	function automatic logic [15:0] ref_read(input logic [15:0] a);
		return ref_mem.exists(a[15:1]) ? ref_mem[a[15:1]] : 16'h0000;
	endfunction

	// Side 0 is the instruction cache, 1 the data cache
	function automatic logic model_hit(input int side, input logic [15:0] a);
		cache_pkg::cache_addr_t ca;
		logic                   found;
		ca = a;
		found = 1'b0;
		for (int slot = 0; slot < 2; slot++) begin
			if (res_valid[side][ca.index][slot] && res_tag[side][ca.index][slot] == ca.tag)
				found = 1'b1;
		end
		return found;
	endfunction

	// Block moves to slot 0; on a miss the old slot 1 entry is evicted
	task automatic model_touch(input int side, input logic [15:0] a);
		cache_pkg::cache_addr_t ca;
		ca = a;
		if (!(res_valid[side][ca.index][0] && res_tag[side][ca.index][0] == ca.tag)) begin
			res_tag[side][ca.index][1] = res_tag[side][ca.index][0];
			res_valid[side][ca.index][1] = res_valid[side][ca.index][0];
			res_tag[side][ca.index][0] = ca.tag;
			res_valid[side][ca.index][0] = 1'b1;
		end
	endtask

	// Address whose block the model says is not resident
	task automatic pick_miss(input int side, output logic [15:0] a);
		int tries;
		tries = 0;
		random_addr(a);
		while (model_hit(side, a) && tries < 32) begin
			random_addr(a);
			tries++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("timeout: %s at time %0t", reason, $time);
		$display("Test failures found");
		$finish;
	endtask

	// Present requests at a falling edge and hold them until served
	task automatic run_access(input logic do_instr, input logic [15:0] iaddr,
		input logic do_read, input logic do_write, input logic [15:0] daddr,
		input logic [15:0] wdata);
		int waited;
		exp_f_stall = do_instr && !model_hit(0, iaddr);
		exp_m_stall = (do_read || do_write) && !model_hit(1, daddr);
		chk_f_stall = 1'b1;
		chk_m_stall = 1'b1;
		if (do_instr) begin
			exp_instr = ref_read(iaddr);
			model_touch(0, iaddr);
		end
		if (do_read || do_write)
			model_touch(1, daddr);
		if (do_write)
			ref_mem[daddr[15:1]] = wdata;
		if (do_read)
			exp_data = ref_read(daddr);
		chk_instr = do_instr;
		chk_data = do_read;
		chk_order = do_instr && (do_read || do_write);
		instr_read = do_instr;
		instr_addr = iaddr;
		data_req.read = do_read;
		data_req.write = do_write;
		data_req.addr = daddr;
		data_req.wdata = wdata;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			chk_f_stall = 1'b0;
			chk_m_stall = 1'b0;
		end while ((f_stall || m_stall) && waited < wait_limit);
		if (f_stall || m_stall) begin
			abort_run("request still stalled after wait limit");
		end else begin
			// Next rising edge serves the request
			@(negedge clk);
			instr_read = 1'b0;
			data_req = '0;
			chk_instr = 1'b0;
			chk_data = 1'b0;
			chk_order = 1'b0;
		end
	endtask

	task automatic finish_test(input string name, input int start_errs);
		test_count++;
		if (error_count == start_errs) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", test_count, name, error_count - start_errs);
		end
	endtask

	initial begin
		int          start_errs;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] wa;
		logic [31:0] r;
		rst_n = 1'b0;
		instr_read = 1'b0;
		instr_addr = '0;
		data_req = '0;
		{chk_f_stall, exp_f_stall, chk_m_stall, exp_m_stall} = '0;
		{chk_instr, chk_data, chk_order} = '0;
		exp_instr = '0;
		exp_data = '0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		lfsr_state = 32'h51c4e84b;
		for (int s = 0; s < cache_pkg::sets; s++) begin
			res_valid[0][s] = '{1'b0, 1'b0};
			res_valid[1][s] = '{1'b0, 1'b0};
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Nothing requested, nothing stalls
		start_errs = error_count;
		{chk_f_stall, exp_f_stall, chk_m_stall, exp_m_stall} = 4'b1010;
		repeat (10) @(negedge clk);
		{chk_f_stall, chk_m_stall} = 2'b00;
		finish_test("idle without stall", start_errs);

		// Empty caches, both ports miss and read zero
		start_errs = error_count;
		random_addr(a);
		run_access(1'b1, a, 1'b0, 1'b0, 16'h0000, 16'h0000);
		random_addr(b);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, b, 16'h0000);
		finish_test("first read miss", start_errs);

		// Write allocate, read back, neighbour word hits
		start_errs = error_count;
		random_addr(wa);
		draw_bits(16, r);
		run_access(1'b0, 16'h0000, 1'b0, 1'b1, wa, r[15:0]);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, wa, 16'h0000);
		b = {wa[15:4], wa[3:1] + 3'd1, 1'b0};
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, b, 16'h0000);
		finish_test("write then read", start_errs);

		// Fetch sees the written word through memory
		start_errs = error_count;
		run_access(1'b1, wa, 1'b0, 1'b0, 16'h0000, 16'h0000);
		finish_test("write-through fetch", start_errs);

		// Order A B A C leaves B as the evicted block
		start_errs = error_count;
		random_addr(a);
		b = {a[15:10] + 6'd1, a[9:0]};
		c = {a[15:10] + 6'd2, a[9:0]};
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, a, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, b, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, a, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, c, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, a, 16'h0000);
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, b, 16'h0000);
		finish_test("lru replacement", start_errs);

		// Both sides miss together
		start_errs = error_count;
		pick_miss(0, a);
		pick_miss(1, b);
		run_access(1'b1, a, 1'b1, 1'b0, b, 16'h0000);
		finish_test("simultaneous misses", start_errs);

		$display("tests %0d, failed tests %0d, check errors %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0 && failed_tests == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: sim.f
src/cache_pkg.sv
src/memory4c.sv
src/two_way_cache_array.sv
src/cache_fill_fsm.sv
src/cache_subsystem.sv
test/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run the cache testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module cache_tb -o cache_sim

./obj_dir/cache_sim | tee sim.log

# The testbench exits cleanly either way, so the log decides
grep -q "All tests passed!" sim.log
